//--- rsa.f
rsa_pkg.sv
rsa_pe.sv
rsa_array.sv
rsa_ctrl.sv
rsa_config.sv
rsa_adder.sv
rsa_top.sv
rsa_clkgen.sv
rsa_monitor.sv
tb_rsa.sv

//--- rsa_adder.sv
// per-row bias adder stage
`timescale 1ns/1ps
`default_nettype none

module rsa_adder (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_shift,
    input  logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] i_drain_col,
    input  logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] i_bias,
    input  logic [rsa_pkg::MODE_W-1:0]           i_mode,
    output logic                                 o_c_val,
    output logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] o_c_data
);
    import rsa_pkg::*;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_c_val <= 1'b0;
        end else begin
            o_c_val <= i_shift;   // tracks the data register
        end
    end

    for (genvar i = 0; i < ROWS; i++) begin : g_lane
        logic [DW-1:0] drn;
        logic [DW-1:0] bia;

        assign drn = i_drain_col[i*DW +: DW];
        assign bia = i_bias[i*DW +: DW];

        always_ff @(posedge clk) begin
            if (i_shift) begin
                case (i_mode)
                    MODE_ADD: o_c_data[i*DW +: DW] <= bia + drn;
                    MODE_SUB: o_c_data[i*DW +: DW] <= bia - drn;   // wraps below zero
                    default:  o_c_data[i*DW +: DW] <= drn;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rsa_array.sv
// skewed operand feed and pe grid
`timescale 1ns/1ps
`default_nettype none

module rsa_array (
    input  logic                                  clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_op_val,
    input  logic                                  i_op_first,
    input  logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0]  i_a_col,
    input  logic [rsa_pkg::COLS*rsa_pkg::DW-1:0]  i_b_row,
    input  logic                                  i_load,
    input  logic                                  i_shift,
    output logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0]  o_drain_col
);
    import rsa_pkg::*;

    // horizontal links where index c is the west input of column c
    wire [DW-1:0] a_h     [ROWS][COLS+1];
    wire          val_h   [ROWS][COLS+1];
    wire          first_h [ROWS][COLS+1];
    wire [DW-1:0] drn_h   [ROWS][COLS+1];
    // vertical links where index r is the south input of row r
    wire [DW-1:0] b_v     [ROWS+1][COLS];

    // row r gets an input register plus r skew stages and the flags ride along
    for (genvar r = 0; r < ROWS; r++) begin : g_a_skew
        logic [DW-1:0] a_sk [r+1];
        logic [r:0]    val_sk;
        logic [r:0]    first_sk;

        always_ff @(posedge clk) begin
            a_sk[0] <= i_a_col[r*DW +: DW];
            for (int k = 1; k <= r; k++) begin
                a_sk[k] <= a_sk[k-1];
            end
        end

        always_ff @(posedge clk) begin
            if (!i_rst_n) begin
                val_sk   <= '0;
                first_sk <= '0;
            end else begin
                val_sk[0]   <= i_op_val;
                first_sk[0] <= i_op_val & i_op_first;
                for (int k = 1; k <= r; k++) begin
                    val_sk[k]   <= val_sk[k-1];
                    first_sk[k] <= first_sk[k-1];
                end
            end
        end

        assign a_h[r][0]       = a_sk[r];
        assign val_h[r][0]     = val_sk[r];
        assign first_h[r][0]   = first_sk[r];
        assign drn_h[r][COLS]  = '0;                  // nothing east of the last column
        assign o_drain_col[r*DW +: DW] = drn_h[r][0];
    end

    // column c gets an input register plus c skew stages
    for (genvar c = 0; c < COLS; c++) begin : g_b_skew
        logic [DW-1:0] b_sk [c+1];

        always_ff @(posedge clk) begin
            b_sk[0] <= i_b_row[c*DW +: DW];
            for (int k = 1; k <= c; k++) begin
                b_sk[k] <= b_sk[k-1];
            end
        end

        assign b_v[0][c] = b_sk[c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_pe_row
        for (genvar c = 0; c < COLS; c++) begin : g_pe_col
            rsa_pe u_pe (
                .clk          (clk),
                .i_rst_n      (i_rst_n),
                .i_a_west     (a_h[r][c]),
                .i_b_south    (b_v[r][c]),
                .i_val_west   (val_h[r][c]),
                .i_first_west (first_h[r][c]),
                .o_a_east     (a_h[r][c+1]),
                .o_b_north    (b_v[r+1][c]),
                .o_val_east   (val_h[r][c+1]),
                .o_first_east (first_h[r][c+1]),
                .i_load       (i_load),
                .i_shift      (i_shift),
                .i_drain_east (drn_h[r][c+1]),
                .o_drain      (drn_h[r][c])
            );
        end
    end

endmodule

`default_nettype wire

//--- rsa_clkgen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module rsa_clkgen (
    output logic clk,
    output logic o_rst_n
);
    localparam int PERIOD     = 40;   // ns
    localparam int RST_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        o_rst_n <= 1'b1;   // released on a rising edge
    end

endmodule

`default_nettype wire

//--- rsa_config.sv
// bias and mode registers
`timescale 1ns/1ps
`default_nettype none

module rsa_config (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_cfg_we,
    input  logic [rsa_pkg::CFG_AW-1:0]           i_cfg_addr,
    input  logic [rsa_pkg::DW-1:0]               i_cfg_data,
    output logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] o_bias,
    output logic [rsa_pkg::MODE_W-1:0]           o_mode
);
    import rsa_pkg::*;

    logic [ROWS-1:0][DW-1:0] bias_q;   // one word per row lane
    logic [MODE_W-1:0]       mode_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            bias_q <= '0;
            mode_q <= MODE_PASS;
        end else if (i_cfg_we) begin
            if (i_cfg_addr < CFG_AW'(ROWS)) begin
                bias_q[i_cfg_addr] <= i_cfg_data;
            end else if (i_cfg_addr == CFG_AW'(ROWS)) begin
                mode_q <= i_cfg_data[MODE_W-1:0];   // upper data bits dropped
            end
            // higher addresses fall through
        end
    end

    assign o_bias = bias_q;
    assign o_mode = mode_q;

endmodule

`default_nettype wire

//--- rsa_ctrl.sv
// drain sequencer
`timescale 1ns/1ps
`default_nettype none

module rsa_ctrl (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_op_val,
    input  logic i_op_last,
    output logic o_load,
    output logic o_shift
);
    import rsa_pkg::*;

    logic              dly_act;
    logic [DLY_W-1:0]  dly_cnt;    // cycles since the last beat
    logic [BEAT_W-1:0] beat_cnt;   // drain beats already sent

    // load lands DRAIN_DELAY cycles after the last beat
    assign o_load = dly_act && (dly_cnt == DLY_W'(DRAIN_DELAY));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            dly_act <= 1'b0;
            dly_cnt <= '0;
        end else if (i_op_val && i_op_last) begin
            dly_act <= 1'b1;
            dly_cnt <= DLY_W'(1);
        end else if (o_load) begin
            dly_act <= 1'b0;
        end else if (dly_act) begin
            dly_cnt <= dly_cnt + 1'b1;
        end
    end

    // shift window of COLS cycles right after the load
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_shift  <= 1'b0;
            beat_cnt <= '0;
        end else if (o_load) begin
            o_shift  <= 1'b1;
            beat_cnt <= '0;
        end else if (o_shift) begin
            if (beat_cnt == BEAT_W'(COLS - 1)) begin
                o_shift <= 1'b0;   // back to idle
            end
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rsa_monitor.sv
// output checker with reference model
`timescale 1ns/1ps
`default_nettype none

module rsa_monitor (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_op_val,
    input  logic                                 i_op_first,
    input  logic                                 i_op_last,
    input  logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] i_a_col,
    input  logic [rsa_pkg::COLS*rsa_pkg::DW-1:0] i_b_row,
    input  logic                                 i_cfg_we,
    input  logic [rsa_pkg::CFG_AW-1:0]           i_cfg_addr,
    input  logic [rsa_pkg::DW-1:0]               i_cfg_data,
    input  logic                                 i_c_val,
    input  logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] i_c_data,
    output int                                   o_pending,
    output int                                   o_err_mismatch,
    output int                                   o_err_missing,
    output int                                   o_err_extra
);
    import rsa_pkg::*;

    logic [DW-1:0]      acc  [ROWS][COLS];   // reference c of the job being fed
    logic [DW-1:0]      bias [ROWS];         // shadow of the config block
    logic [MODE_W-1:0]  mode;
    int                 cyc;
    int                 due_q  [$];          // cycle each drain beat is expected
    int                 beat_q [$];
    logic [ROWS*DW-1:0] exp_q  [$];

    function automatic logic [DW-1:0] apply_mode(input logic [MODE_W-1:0] m,
                                                 input logic [DW-1:0] b,
                                                 input logic [DW-1:0] c);
        case (m)
            MODE_ADD: return b + c;
            MODE_SUB: return b - c;
            default:  return c;   // pass, and the unused code 3
        endcase
    endfunction

    task automatic take_beat();
        logic [DW-1:0]      a;
        logic [DW-1:0]      b;
        logic [DW-1:0]      p;
        logic [ROWS*DW-1:0] word;
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < COLS; j++) begin
                a = i_a_col[i*DW +: DW];
                b = i_b_row[j*DW +: DW];
                p = a * b;   // wraps at DW bits
                acc[i][j] = i_op_first ? p : acc[i][j] + p;
            end
        end
        if (i_op_last) begin
            // mode and bias as they stand at the last beat
            for (int k = 0; k < COLS; k++) begin
                for (int i = 0; i < ROWS; i++) begin
                    word[i*DW +: DW] = apply_mode(mode, bias[i], acc[i][k]);
                end
                due_q.push_back(cyc + DRAIN_DELAY + 2 + k);
                beat_q.push_back(k);
                exp_q.push_back(word);
            end
        end
    endtask

    task automatic check_output();
        logic [ROWS*DW-1:0] exp_word;
        logic [DW-1:0]      want;
        logic [DW-1:0]      got;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            exp_word = exp_q[0];
            if (i_c_val !== 1'b1) begin
                o_err_missing++;
                $display("missing output beat %0d at cycle %0d, o_c_val was not set",
                         beat_q[0], cyc);
            end else begin
                for (int i = 0; i < ROWS; i++) begin
                    want = exp_word[i*DW +: DW];
                    got  = i_c_data[i*DW +: DW];
                    if (got !== want) begin
                        o_err_mismatch++;
                        $display("mismatch o_c_data[%0d] beat %0d: expected %h, got %h",
                                 i, beat_q[0], want, got);
                    end
                end
            end
            void'(due_q.pop_front());
            void'(beat_q.pop_front());
            void'(exp_q.pop_front());
        end else if (i_c_val !== 1'b0) begin
            o_err_extra++;
            $display("unexpected output beat at cycle %0d, no result was due", cyc);
        end
    endtask

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!i_rst_n) begin
            cyc  = 0;
            mode = MODE_PASS;
            for (int i = 0; i < ROWS; i++) begin
                bias[i] = '0;
            end
            due_q.delete();
            beat_q.delete();
            exp_q.delete();
            o_pending      = 0;
            o_err_mismatch = 0;
            o_err_missing  = 0;
            o_err_extra    = 0;
        end else begin
            cyc++;
            check_output();
            if (i_op_val) begin
                take_beat();
            end
            if (i_cfg_we) begin   // seen from the next cycle on
                if (i_cfg_addr < CFG_AW'(ROWS)) begin
                    bias[int'(i_cfg_addr)] = i_cfg_data;
                end else if (i_cfg_addr == CFG_AW'(ROWS)) begin
                    mode = i_cfg_data[MODE_W-1:0];
                end
            end
            o_pending = due_q.size();
        end
    end

endmodule

`default_nettype wire

//--- rsa_pe.sv
// multiply-accumulate processing element
`timescale 1ns/1ps
`default_nettype none

module rsa_pe (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [rsa_pkg::DW-1:0] i_a_west,
    input  logic [rsa_pkg::DW-1:0] i_b_south,
    input  logic                   i_val_west,
    input  logic                   i_first_west,
    output logic [rsa_pkg::DW-1:0] o_a_east,
    output logic [rsa_pkg::DW-1:0] o_b_north,
    output logic                   o_val_east,
    output logic                   o_first_east,
    input  logic                   i_load,
    input  logic                   i_shift,
    input  logic [rsa_pkg::DW-1:0] i_drain_east,
    output logic [rsa_pkg::DW-1:0] o_drain
);
    import rsa_pkg::*;

    logic [DW-1:0] prod;
    logic [DW-1:0] acc_q;
    logic [DW-1:0] acc_d;
    logic [DW-1:0] drain_q;

    assign prod = i_a_west * i_b_south;   // low DW bits only

    // first beat of a job restarts the sum
    always_comb begin
        acc_d = acc_q;
        if (i_val_west) begin
            acc_d = i_first_west ? prod : acc_q + prod;
        end
    end

    always_ff @(posedge clk) begin
        acc_q     <= acc_d;
        o_a_east  <= i_a_west;
        o_b_north <= i_b_south;
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_val_east   <= 1'b0;
            o_first_east <= 1'b0;
        end else begin
            o_val_east   <= i_val_west;
            o_first_east <= i_first_west;
        end
    end

    // load takes acc_d so the far corner's last product lands in the same edge
    always_ff @(posedge clk) begin
        if (i_load) begin
            drain_q <= acc_d;
        end else if (i_shift) begin
            drain_q <= i_drain_east;   // one column west per cycle
        end
    end

    assign o_drain = drain_q;

endmodule

`default_nettype wire

//--- rsa_pkg.sv
// systolic array shared constants
`default_nettype none

package rsa_pkg;

    // array geometry
    localparam int ROWS = 4;    // pe rows and a words per beat
    localparam int COLS = 4;    // pe columns, b words per beat and drain beats

    localparam int DW = 16;     // data word where all arithmetic wraps

    // bias words at config addresses 0..ROWS-1 and the mode at ROWS
    localparam int CFG_AW = 3;
    localparam int MODE_W = 2;

    localparam logic [MODE_W-1:0] MODE_PASS = 2'd0;
    localparam logic [MODE_W-1:0] MODE_ADD  = 2'd1;   // bias + c
    localparam logic [MODE_W-1:0] MODE_SUB  = 2'd2;   // bias - c
    // code 3 is treated as pass by the adder

    // last beat to drain load covers the skew across the whole grid
    localparam int DRAIN_DELAY = ROWS + COLS - 1;

    // controller counter widths
    localparam int DLY_W  = $clog2(DRAIN_DELAY + 1);
    localparam int BEAT_W = $clog2(COLS + 1);

endpackage

`default_nettype wire

//--- rsa_top.sv
// systolic multiply array top
`timescale 1ns/1ps
`default_nettype none

module rsa_top (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    // operand beats
    input  logic                                 i_op_val,
    input  logic                                 i_op_first,
    input  logic                                 i_op_last,
    input  logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] i_a_col,
    input  logic [rsa_pkg::COLS*rsa_pkg::DW-1:0] i_b_row,
    // config writes
    input  logic                                 i_cfg_we,
    input  logic [rsa_pkg::CFG_AW-1:0]           i_cfg_addr,
    input  logic [rsa_pkg::DW-1:0]               i_cfg_data,
    // drained results with word i for row i
    output logic                                 o_c_val,
    output logic [rsa_pkg::ROWS*rsa_pkg::DW-1:0] o_c_data
);
    import rsa_pkg::*;

    logic                 load;
    logic                 shift;
    logic [ROWS*DW-1:0]   drain_col;
    logic [ROWS*DW-1:0]   bias;
    logic [MODE_W-1:0]    mode;

    rsa_ctrl u_ctrl (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_op_val  (i_op_val),
        .i_op_last (i_op_last),
        .o_load    (load),
        .o_shift   (shift)
    );

    rsa_array u_array (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_op_val    (i_op_val),
        .i_op_first  (i_op_first),
        .i_a_col     (i_a_col),
        .i_b_row     (i_b_row),
        .i_load      (load),
        .i_shift     (shift),
        .o_drain_col (drain_col)
    );

    rsa_config u_config (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .o_bias     (bias),
        .o_mode     (mode)
    );

    rsa_adder u_adder (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_shift     (shift),
        .i_drain_col (drain_col),
        .i_bias      (bias),
        .i_mode      (mode),
        .o_c_val     (o_c_val),
        .o_c_data    (o_c_data)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rsa -f rsa.f \
    -Mdir obj_rsa -o sim_rsa > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_rsa/sim_rsa > sim.log 2>&1
cat sim.log

grep -q "^Test completed successfully$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_rsa.sv
// systolic array testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rsa;
    import rsa_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NJOBS      = 40;
    localparam int MAX_LEN    = 8;
    localparam int MAX_GAP    = 3;
    // worst case per job covers gapped beats, config wait and writes, drain and margin
    localparam int JOB_CYC    = MAX_LEN * (1 + MAX_GAP) + 3 * MAX_GAP + DRAIN_DELAY + COLS + 20;
    localparam int WD_CYCLES  = NJOBS * JOB_CYC + 100;

    logic               clk;
    logic               rst_n;
    logic               op_val;
    logic               op_first;
    logic               op_last;
    logic [ROWS*DW-1:0] a_col;
    logic [COLS*DW-1:0] b_row;
    logic               cfg_we;
    logic [CFG_AW-1:0]  cfg_addr;
    logic [DW-1:0]      cfg_data;
    logic               c_val;
    logic [ROWS*DW-1:0] c_data;
    int                 pending;
    int                 err_mismatch;
    int                 err_missing;
    int                 err_extra;

    logic [31:0] seed;
    int          cyc;         // rising edges since stimulus start
    int          prev_last;   // cycle of the previous last beat

    rsa_clkgen u_clkgen (.clk(clk), .o_rst_n(rst_n));

    rsa_top UUT (
        .clk        (clk),
        .i_rst_n    (rst_n),
        .i_op_val   (op_val),
        .i_op_first (op_first),
        .i_op_last  (op_last),
        .i_a_col    (a_col),
        .i_b_row    (b_row),
        .i_cfg_we   (cfg_we),
        .i_cfg_addr (cfg_addr),
        .i_cfg_data (cfg_data),
        .o_c_val    (c_val),
        .o_c_data   (c_data)
    );

    rsa_monitor u_monitor (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_op_val       (op_val),
        .i_op_first     (op_first),
        .i_op_last      (op_last),
        .i_a_col        (a_col),
        .i_b_row        (b_row),
        .i_cfg_we       (cfg_we),
        .i_cfg_addr     (cfg_addr),
        .i_cfg_data     (cfg_data),
        .i_c_val        (c_val),
        .i_c_data       (c_data),
        .o_pending      (pending),
        .o_err_mismatch (err_mismatch),
        .o_err_missing  (err_missing),
        .o_err_extra    (err_extra)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int pick(input int n);
        return int'(lcg_next() >> 16) % n;   // high half of the lcg state
    endfunction

    function automatic logic [ROWS*DW-1:0] rand_bus();
        logic [ROWS*DW-1:0] v;
        logic [31:0]        r;
        for (int i = 0; i < ROWS; i++) begin
            r = lcg_next();
            v[i*DW +: DW] = r[31:32-DW];
        end
        return v;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        cyc++;
        op_val   <= 1'b0;
        op_first <= 1'b0;
        op_last  <= 1'b0;
        cfg_we   <= 1'b0;
        a_col    <= rand_bus();   // junk data while op_val is low
        b_row    <= rand_bus();
    endtask

    task automatic send_beat(input logic first, input logic last);
        @(posedge clk);
        cyc++;
        op_val   <= 1'b1;
        op_first <= first;
        op_last  <= last;
        cfg_we   <= 1'b0;
        a_col    <= rand_bus();
        b_row    <= rand_bus();
        if (last) begin
            prev_last = cyc;
        end
    endtask

    task automatic write_cfg(input logic [CFG_AW-1:0] addr, input logic [DW-1:0] data);
        @(posedge clk);
        cyc++;
        op_val   <= 1'b0;
        op_first <= 1'b0;
        op_last  <= 1'b0;
        cfg_we   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
    endtask

    task automatic change_config(input int job);
        int n;
        n = 1 + pick(3);
        // the previous drain must be out before bias or mode move
        while (cyc + 1 < prev_last + DRAIN_DELAY + COLS + 3) idle_cycle();
        for (int w = 0; w < n; w++) begin
            // mode gets a good share and addresses above ROWS are ignored
            write_cfg((pick(3) == 0) ? CFG_AW'(ROWS) : CFG_AW'(pick(1 << CFG_AW)),
                      DW'(lcg_next() >> 16));
        end
        // early jobs walk every mode code, each with a fresh bias word
        if (job < (1 << MODE_W)) begin
            write_cfg(CFG_AW'(job % ROWS), DW'(lcg_next() >> 16));
            write_cfg(CFG_AW'(ROWS), DW'(job));
        end
    endtask

    task automatic run_job(input int len);
        for (int b = 0; b < len; b++) begin
            if (b > 0 && pick(3) == 0) begin
                repeat (1 + pick(MAX_GAP)) idle_cycle();
            end
            // first beat waits for the previous load and last beat for its drain window
            if (b == 0) begin
                while (cyc + 1 < prev_last + DRAIN_DELAY) idle_cycle();
            end
            if (b == len - 1) begin
                while (cyc + 1 < prev_last + DRAIN_DELAY + COLS) idle_cycle();
            end
            send_beat(b == 0, b == len - 1);
        end
    endtask

    initial begin
        seed      = 32'h2226;
        cyc       = 0;
        prev_last = -100;
        op_val    = 1'b0;
        op_first  = 1'b0;
        op_last   = 1'b0;
        a_col     = '0;
        b_row     = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        @(posedge clk);
        while (!rst_n) @(posedge clk);
        repeat (2) idle_cycle();
        for (int j = 0; j < NJOBS; j++) begin
            if (j < (1 << MODE_W) || pick(3) == 0) begin
                change_config(j);
            end
            repeat (pick(MAX_GAP + 1)) idle_cycle();
            run_job(1 + pick(MAX_LEN));
        end
        idle_cycle();
        while (pending != 0) idle_cycle();   // last drain out
        repeat (COLS + 4) idle_cycle();      // catch stray beats
        $display("errors: mismatch %0d, missing %0d, extra %0d",
                 err_mismatch, err_missing, err_extra);
        if (err_mismatch + err_missing + err_extra == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
